//--- common/fpu_const_pkg.sv
package fpu_const_pkg;

	localparam logic [2:0] FPU_RM_RNE = 3'd0;
	localparam logic [2:0] FPU_RM_RTZ = 3'd1;
	localparam logic [2:0] FPU_RM_RDN = 3'd2;
	localparam logic [2:0] FPU_RM_RUP = 3'd3;
	localparam logic [2:0] FPU_RM_RMM = 3'd4;

	localparam logic signed [9:0] EXP_BIAS = 10'sd127;
	localparam logic signed [9:0] EXP_MAX = 10'sd127;
	localparam logic signed [9:0] EXP_MIN = -10'sd126;

	// biased exponent field shared by infinity and NaN
	localparam logic [9:0] EXP_SPECIAL = 10'h0ff;
	localparam logic [23:0] QNAN_MAN = 24'hc00000;
	localparam logic [23:0] INF_MAN = 24'h800000;

endpackage

//--- common/fpu_operand_if.sv
interface fpu_operand_if
	import fpu_types_pkg::*;
();

	man_t	man;
	exp_t	exp;
	logic	sgn;
	logic	zero;
	logic	inf;
	logic	snan;
	logic	qnan;

	modport src (
		output man, exp, sgn, zero, inf, snan, qnan
	);

	modport dst (
		input man, exp, sgn, zero, inf, snan, qnan
	);

endinterface

//--- common/fpu_result_if.sv
interface fpu_result_if
	import fpu_types_pkg::*;
();

	man_t	man;
	exp_t	exp;
	logic	sgn;
	logic	round_bit;
	logic	sticky_bit;
	logic	iv;
	// exp holds the biased field when final_res is set
	logic	final_res;
	logic	ready;

	modport src (
		output man, exp, sgn, round_bit, sticky_bit, iv, final_res, ready
	);

	modport dst (
		input man, exp, sgn, round_bit, sticky_bit, iv, final_res, ready
	);

endinterface

//--- common/fpu_types_pkg.sv
package fpu_types_pkg;

	// mantissa with the hidden bit at [23]
	typedef logic [23:0] man_t;

	// unbiased exponent, signed, with headroom past the single range
	typedef logic signed [9:0] exp_t;

	// raw IEEE-754 single
	typedef logic [31:0] fp32_t;

	// rounding mode code
	typedef logic [2:0] rm_t;

endpackage

//--- files.f
+incdir+test
common/fpu_types_pkg.sv
common/fpu_const_pkg.sv
common/fpu_operand_if.sv
common/fpu_result_if.sv
verilog/float_unpack.sv
float_adder/rshifter.sv
float_adder/leading_zero_counter_24.sv
float_adder/float_adder.sv
verilog/float_round_pack.sv
verilog/fp_add_unit.sv
test/fp_add_tb.sv

//--- float_adder/float_adder.sv
module float_adder
	import fpu_types_pkg::*, fpu_const_pkg::*;
(
	input	logic			clk,
	input	logic			reset,
	input	logic			load,
	input	logic			op_add,
	input	logic			op_sub,
	input	rm_t			rm,
	fpu_operand_if.dst		a,
	fpu_operand_if.dst		b,
	fpu_result_if.src		res
);

	typedef enum logic [1:0] {IDLE, ALIGN, ADD, NORM} state_t;

	state_t			state;

	logic			sgn_b_eff;
	logic			sub_eff;
	logic			swap;
	logic			iv_int;
	logic			nan_case;
	logic			inf_case;
	logic			zero_case;
	logic			special;
	logic			sgn_y;

	logic			sub_q;
	man_t			man_a_q;
	man_t			man_b_q;
	exp_t			exp_a_q;
	exp_t			exp_b_q;
	logic			guard_q;
	logic			round_q;
	logic			sticky_q;

	exp_t			align;
	logic	[4:0]	shift_sel;
	logic	[25:0]	shift_in;
	logic	[25:0]	shift_out;
	logic			shift_sticky;

	logic	[24:0]	sum;
	logic	[4:0]	lz;
	logic			lz_zero;

	assign sgn_b_eff = b.sgn ^ op_sub;
	assign sub_eff = a.sgn ^ sgn_b_eff;
	assign swap = (a.exp < b.exp) || ((a.exp == b.exp) && (a.man < b.man));

	assign iv_int = a.snan || b.snan || (sub_eff && a.inf && b.inf);
	assign nan_case = iv_int || a.qnan || b.qnan;
	assign inf_case = a.inf || b.inf;
	// both zero, or x - x
	assign zero_case = (a.zero && b.zero) ||
		(sub_eff && (a.exp == b.exp) && (a.man == b.man));
	assign special = nan_case || inf_case || zero_case || a.zero || b.zero;

	always_comb begin
		if (inf_case)
			sgn_y = a.inf ? a.sgn : sgn_b_eff;
		else if (zero_case)
			sgn_y = (a.zero && b.zero && !sub_eff) ? a.sgn : (rm == FPU_RM_RDN);
		else if (a.zero || swap)
			sgn_y = sgn_b_eff;
		else
			sgn_y = a.sgn;
	end

	// smaller operand, negated for an effective subtract
	assign align = exp_a_q - exp_b_q;
	assign shift_sel = |align[9:5] ? 5'h1f : align[4:0];
	assign shift_in = sub_q ? -{man_b_q, 2'b00} : {man_b_q, 2'b00};

	always_ff @(posedge clk, posedge reset) begin
		if (reset) begin
			state <= IDLE;
			res.ready <= 1'b0;
		end else if (load) begin
			if ((op_add || op_sub) && !special) begin
				state <= ALIGN;
				res.ready <= 1'b0;
			end else begin
				state <= IDLE;
				res.ready <= op_add || op_sub;
			end
		end else begin
			case (state)
				IDLE:		res.ready <= 1'b0;
				ALIGN:		state <= ADD;
				ADD:		state <= NORM;
				NORM: begin
					state <= IDLE;
					res.ready <= 1'b1;
				end
				default:	state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (load) begin
			sub_q <= sub_eff;
			res.iv <= iv_int;
			res.sgn <= sgn_y;
			res.round_bit <= 1'b0;
			res.sticky_bit <= 1'b0;
			res.final_res <= nan_case || inf_case || zero_case;
			if (nan_case) begin
				res.man <= QNAN_MAN;
				res.exp <= EXP_SPECIAL;
				res.sgn <= 1'b0;
			end else if (inf_case) begin
				res.man <= INF_MAN;
				res.exp <= EXP_SPECIAL;
			end else if (zero_case) begin
				res.man <= 24'd0;
				res.exp <= 10'd0;
			end else if (b.zero) begin
				res.man <= a.man;
				res.exp <= a.exp;
			end else if (a.zero) begin
				res.man <= b.man;
				res.exp <= b.exp;
			end
			// larger magnitude always ends up in the a slot
			man_a_q <= swap ? b.man : a.man;
			exp_a_q <= swap ? b.exp : a.exp;
			man_b_q <= swap ? a.man : b.man;
			exp_b_q <= swap ? a.exp : b.exp;
		end else begin
			case (state)
				ALIGN: begin
					man_b_q <= shift_out[25:2];
					guard_q <= shift_out[1];
					round_q <= shift_out[0];
					sticky_q <= shift_sticky;
				end
				ADD:	sum <= {1'b0, man_a_q} + {1'b0, man_b_q};
				NORM: begin
					if (!sub_q && sum[24]) begin
						res.man <= sum[24:1];
						res.exp <= exp_a_q + 10'sd1;
						res.round_bit <= sum[0];
						res.sticky_bit <= guard_q | round_q | sticky_q;
					end else if (sum[23]) begin
						res.man <= sum[23:0];
						res.exp <= exp_a_q;
						res.round_bit <= guard_q;
						res.sticky_bit <= round_q | sticky_q;
					end else if (sum[22]) begin
						res.man <= {sum[22:0], guard_q};
						res.exp <= exp_a_q - 10'sd1;
						res.round_bit <= round_q;
						res.sticky_bit <= sticky_q;
					end else begin
						// deep cancellation only with align <= 1, so this is exact
						res.man <= lz_zero ? {guard_q, 23'd0} :
							({sum[22:0], guard_q} << (lz - 5'd1));
						res.exp <= exp_a_q - {5'd0, lz};
						res.round_bit <= 1'b0;
						res.sticky_bit <= 1'b0;
					end
				end
				default: ;
			endcase
		end
	end

	rshifter #(.WIDTH(26), .SEL_WIDTH(5)) align_shifter (
		.in(shift_in),
		.sel(shift_sel),
		.sgn(sub_q),
		.out(shift_out),
		.sticky_bit(shift_sticky)
	);

	leading_zero_counter_24 norm_lzc (
		.in(sum[23:0]),
		.y(lz),
		.a(lz_zero)
	);

	ready_single: assert property (@(posedge clk) disable iff (reset)
		res.ready && !load |=> !res.ready);

	ready_idle: assert property (@(posedge clk) disable iff (reset)
		res.ready |-> state == IDLE);

endmodule

//--- float_adder/leading_zero_counter_24.sv
module leading_zero_counter_24
	import fpu_types_pkg::*;
(
	input	man_t			in,
	output	logic	[4:0]	y,
	output	logic			a
);

	// higher bits overwrite lower ones, so the top set bit wins
	always_comb begin
		y = 5'd24;
		for (int i = 0; i < 24; i++) begin
			if (in[i])
				y = 5'(23 - i);
		end
	end

	assign a = ~|in;

endmodule

//--- float_adder/rshifter.sv
module rshifter #(
	parameter int WIDTH = 26,
	parameter int SEL_WIDTH = 5
) (
	input	logic	[WIDTH-1:0]		in,
	input	logic	[SEL_WIDTH-1:0]	sel,
	input	logic					sgn,
	output	logic	[WIDTH-1:0]		out,
	output	logic					sticky_bit
);

	// room below the word for the largest shift
	localparam int LOW = 2 ** SEL_WIDTH;

	logic signed	[WIDTH+LOW:0]	ext;
	logic signed	[WIDTH+LOW:0]	shifted;

	// sgn sits above in so a negated full-width value keeps its sign
	assign ext = {sgn, in, {LOW{1'b0}}};
	assign shifted = ext >>> sel;

	assign out = shifted[WIDTH+LOW-1:LOW];
	assign sticky_bit = |shifted[LOW-1:0];

endmodule

//--- run.sh
#!/bin/sh
verilator --binary --timing --assert --top-module fp_add_tb -f files.f -o fp_add_sim \
	&& ./obj_dir/fp_add_sim | tee /dev/stderr | grep -q "ALL TESTS PASSED" \
	&& exit 0 || exit 1

//--- test/fp_add_model.svh
`ifndef FP_ADD_MODEL_SVH
`define FP_ADD_MODEL_SVH

// result packed as {normal_path, y, invalid, overflow, underflow, inexact}
function automatic logic [36:0] model_add(input logic [31:0] a, input logic [31:0] b,
	input logic sub, input logic [2:0] rm);
	logic	[7:0]	ea;
	logic	[7:0]	eb;
	logic			sa;
	logic			sb;
	logic			nan;
	logic			snan;
	logic			inf_inf;
	logic	[279:0]	big_a;
	logic	[279:0]	big_b;
	logic	[279:0]	mag;
	logic			s;
	logic	[24:0]	man;
	logic			r;
	logic			st;
	logic			up;
	logic			to_max;
	int				p;
	int				e;

	ea = a[30:23];
	eb = b[30:23];
	sa = a[31];
	sb = b[31] ^ sub;
	nan = (ea == 8'hff && a[22:0] != '0) || (eb == 8'hff && b[22:0] != '0);
	snan = (ea == 8'hff && a[22:0] != '0 && !a[22]) || (eb == 8'hff && b[22:0] != '0 && !b[22]);
	inf_inf = ea == 8'hff && eb == 8'hff && a[22:0] == '0 && b[22:0] == '0 && sa != sb;
	if (nan || inf_inf)
		return {1'b0, 32'h7fc00000, snan || inf_inf, 3'b000};
	if (ea == 8'hff)
		return {1'b0, sa, a[30:0], 4'b0000};
	if (eb == 8'hff)
		return {1'b0, sb, b[30:0], 4'b0000};
	// subnormals count as zero
	if (ea == 8'd0 && eb == 8'd0)
		return {1'b0, (sa == sb) ? sa : (rm == FPU_RM_RDN), 31'd0, 4'b0000};
	if (eb == 8'd0)
		return {1'b0, a, 4'b0000};
	if (ea == 8'd0)
		return {1'b0, sb, b[30:0], 4'b0000};

	// both scaled to an lsb of 2^-149
	big_a = 280'({1'b1, a[22:0]}) << (ea - 8'd1);
	big_b = 280'({1'b1, b[22:0]}) << (eb - 8'd1);
	if (sa == sb) begin
		mag = big_a + big_b;
		s = sa;
	end else if (big_a >= big_b) begin
		mag = big_a - big_b;
		s = sa;
	end else begin
		mag = big_b - big_a;
		s = sb;
	end
	if (mag == '0)
		return {1'b0, rm == FPU_RM_RDN, 31'd0, 4'b0000};

	p = 0;
	for (int i = 0; i < 280; i++) begin
		if (mag[i])
			p = i;
	end
	r = 1'b0;
	st = 1'b0;
	if (p >= 23)
		man = 25'(mag >> (p - 23));
	else
		man = 25'(mag << (23 - p));
	if (p >= 24)
		r = mag[p - 24];
	for (int i = 0; i < p - 24; i++)
		st = st | mag[i];

	case (rm)
		FPU_RM_RNE:	up = r & (st | man[0]);
		FPU_RM_RDN:	up = s & (r | st);
		FPU_RM_RUP:	up = !s & (r | st);
		FPU_RM_RMM:	up = r;
		default:	up = 1'b0;
	endcase
	man = man + 25'(up);
	e = p - 149;
	if (man[24]) begin
		man = man >> 1;
		e = e + 1;
	end

	to_max = (rm == FPU_RM_RTZ) || (rm == FPU_RM_RDN && !s) || (rm == FPU_RM_RUP && s);
	if (e > 127)
		return {1'b1, to_max ? {s, 8'hfe, 23'h7fffff} : {s, 8'hff, 23'd0}, 4'b0101};
	if (e < -126)
		return {1'b1, s, 31'd0, 4'b0011};
	return {1'b1, s, 8'(e + 127), man[22:0], 3'b000, r | st};
endfunction

`endif

//--- test/fp_add_tb.sv
module fp_add_tb
	import fpu_const_pkg::*;
();

	localparam int NUM_OPS = 4000;
	localparam logic [31:0] SEED = 32'd76555;

	logic			clk;
	logic			reset;
	logic			start;
	logic			sub;
	logic	[2:0]	rm;
	logic	[31:0]	a;
	logic	[31:0]	b;
	logic	[31:0]	y;
	logic			invalid;
	logic			overflow;
	logic			underflow;
	logic			inexact;
	logic			done;

	logic	[31:0]	lfsr_state;
	int				value_errors;
	int				protocol_errors;

	`include "fp_add_model.svh"

	fp_add_unit dut (
		.clk(clk),
		.reset(reset),
		.start(start),
		.sub(sub),
		.rm(rm),
		.a(a),
		.b(b),
		.y(y),
		.invalid(invalid),
		.overflow(overflow),
		.underflow(underflow),
		.inexact(inexact),
		.done(done)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	function automatic logic [31:0] take_bits(input int n);
		logic	[31:0]	v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], lfsr_state[0]};
			lfsr_state = lfsr_step(lfsr_state);
		end
		return v;
	endfunction

	// ref_word steers the near-equal class
	function automatic logic [31:0] make_operand(input logic [31:0] ref_word);
		logic	[3:0]	cls;
		logic			s;
		logic	[7:0]	e;
		logic	[22:0]	f;
		logic	[1:0]	d;
		cls = 4'(take_bits(4));
		s = 1'(take_bits(1));
		e = 8'(take_bits(8));
		f = 23'(take_bits(23));
		case (cls)
			4'd5, 4'd6, 4'd7: begin
				e = ref_word[30:23];
				if (e == 8'd0)
					e = 8'd1;
				else if (e == 8'hff)
					e = 8'hfe;
				d = 2'(take_bits(2));
				if (d == 2'd2 && e < 8'hfe)
					e = e + 8'd1;
				else if (d == 2'd3 && e > 8'd1)
					e = e - 8'd1;
				if (cls[0])
					f = {ref_word[22:4], f[3:0]};
			end
			4'd8: begin
				e = 8'd0;
				f = '0;
			end
			4'd9: begin
				e = 8'hff;
				f = '0;
			end
			4'd10: begin
				e = 8'hff;
				f[22] = 1'b1;
			end
			4'd11: begin
				e = 8'hff;
				f[22] = 1'b0;
				if (f == '0)
					f = 23'd1;
			end
			4'd12:	e = 8'd0;
			4'd13, 4'd14:	e = 8'hfe - 8'(take_bits(2));
			4'd15:	e = 8'd1 + 8'(take_bits(2));
			default: begin
				if (e == 8'd0)
					e = 8'd1;
				else if (e == 8'hff)
					e = 8'hfe;
			end
		endcase
		return {s, e, f};
	endfunction

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		assert (actual === expected) else begin
			value_errors++;
			$display("[ERROR] %s expected %h actual %h (a %h b %h sub %0d rm %0d)",
				name, expected, actual, a, b, sub, rm);
		end
	endtask

	task automatic drive_op(output logic [36:0] expv);
		logic	[31:0]	na;
		logic	[31:0]	nb;
		logic			ns;
		logic	[2:0]	nrm;
		na = make_operand(b);
		nb = make_operand(na);
		ns = 1'(take_bits(1));
		nrm = 3'(take_bits(3) % 5);
		a <= na;
		b <= nb;
		sub <= ns;
		rm <= nrm;
		start <= 1'b1;
		expv = model_add(na, nb, ns, nrm);
	endtask

	// restart issues a second start before the first can finish
	task automatic run_op(input logic restart);
		logic	[36:0]	expv;
		int				gap;
		int				cycles;
		logic			got;
		@(posedge clk);
		drive_op(expv);
		if (restart) begin
			gap = expv[36] ? 1 + int'(take_bits(2)) : 1;
			for (int i = 1; i < gap; i++) begin
				@(posedge clk);
				start <= 1'b0;
			end
			@(posedge clk);
			drive_op(expv);
		end
		@(posedge clk);
		start <= 1'b0;
		cycles = 1;
		got = 1'b0;
		while (!got && cycles <= 20) begin
			@(negedge clk);
			if (done)
				got = 1'b1;
			else begin
				@(posedge clk);
				cycles++;
			end
		end
		if (!got) begin
			protocol_errors++;
			$display("timeout: done did not arrive within 20 cycles of start");
		end else begin
			assert (cycles == (expv[36] ? 5 : 2)) else begin
				protocol_errors++;
				$display("done came %0d cycles after start instead of %0d",
					cycles, expv[36] ? 5 : 2);
			end
			check_value("y", expv[35:4], y);
			check_value("invalid", 32'(expv[3]), 32'(invalid));
			check_value("overflow", 32'(expv[2]), 32'(overflow));
			check_value("underflow", 32'(expv[1]), 32'(underflow));
			check_value("inexact", 32'(expv[0]), 32'(inexact));
			@(posedge clk);
			@(negedge clk);
			assert (!done) else begin
				protocol_errors++;
				$display("done stayed high for more than one cycle");
			end
		end
	endtask

	initial begin
		value_errors = 0;
		protocol_errors = 0;
		lfsr_state = SEED;
		reset <= 1'b1;
		start <= 1'b0;
		sub <= 1'b0;
		rm <= 3'd0;
		a <= '0;
		b <= '0;
		repeat (16) @(posedge clk);
		reset <= 1'b0;
		@(negedge clk);
		check_value("done", 32'd0, 32'(done));
		check_value("y", 32'd0, y);
		check_value("flags", 32'd0, 32'({invalid, overflow, underflow, inexact}));

		for (int i = 0; i < NUM_OPS && protocol_errors == 0; i++)
			run_op(3'(take_bits(3)) == 3'd0);

		$display("value errors %0d, protocol errors %0d", value_errors, protocol_errors);
		if (value_errors == 0 && protocol_errors == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

//--- verilog/float_round_pack.sv
module float_round_pack
	import fpu_types_pkg::*, fpu_const_pkg::*;
(
	input	logic			clk,
	input	logic			reset,
	input	logic			start,
	input	rm_t			rm,
	fpu_result_if.dst		res,
	output	fp32_t			y,
	output	logic			invalid,
	output	logic			overflow,
	output	logic			underflow,
	output	logic			inexact,
	output	logic			done
);

	rm_t			rm_q;
	logic			round_up;
	logic			carry;
	man_t			man_r;
	exp_t			exp_r;
	exp_t			exp_biased;
	logic			to_max;
	logic			take;

	fp32_t			y_n;
	logic			invalid_n;
	logic			overflow_n;
	logic			underflow_n;
	logic			inexact_n;

	always_comb begin
		case (rm_q)
			FPU_RM_RNE:	round_up = res.round_bit & (res.sticky_bit | res.man[0]);
			FPU_RM_RTZ:	round_up = 1'b0;
			FPU_RM_RDN:	round_up = res.sgn & (res.round_bit | res.sticky_bit);
			FPU_RM_RUP:	round_up = !res.sgn & (res.round_bit | res.sticky_bit);
			FPU_RM_RMM:	round_up = res.round_bit;
			default:	round_up = 1'b0;
		endcase
	end

	// carry out leaves man_r at zero, i.e. 1.0 at the next exponent
	assign {carry, man_r} = {1'b0, res.man} + {24'd0, round_up};
	assign exp_r = res.exp + {9'd0, carry};
	assign exp_biased = exp_r + EXP_BIAS;

	// overflow saturates when rounding goes toward zero
	assign to_max = (rm_q == FPU_RM_RTZ) || ((rm_q == FPU_RM_RDN) && !res.sgn) ||
		((rm_q == FPU_RM_RUP) && res.sgn);

	always_comb begin
		y_n = {res.sgn, exp_biased[7:0], man_r[22:0]};
		invalid_n = 1'b0;
		overflow_n = 1'b0;
		underflow_n = 1'b0;
		inexact_n = res.round_bit | res.sticky_bit;
		if (res.final_res) begin
			y_n = {res.sgn, res.exp[7:0], res.man[22:0]};
			invalid_n = res.iv;
			inexact_n = 1'b0;
		end else if (exp_r > EXP_MAX) begin
			y_n = to_max ? {res.sgn, 8'hfe, 23'h7fffff} : {res.sgn, 8'hff, 23'd0};
			overflow_n = 1'b1;
			inexact_n = 1'b1;
		end else if (exp_r < EXP_MIN) begin
			y_n = {res.sgn, 31'd0};
			underflow_n = 1'b1;
			inexact_n = 1'b1;
		end
	end

	// a new start overwrites rm_q, so a result landing with it is dropped
	assign take = res.ready && !start;

	always_ff @(posedge clk, posedge reset) begin
		if (reset) begin
			rm_q <= FPU_RM_RNE;
			done <= 1'b0;
			y <= '0;
			invalid <= 1'b0;
			overflow <= 1'b0;
			underflow <= 1'b0;
			inexact <= 1'b0;
		end else begin
			if (start)
				rm_q <= rm;
			done <= take;
			if (take) begin
				y <= y_n;
				invalid <= invalid_n;
				overflow <= overflow_n;
				underflow <= underflow_n;
				inexact <= inexact_n;
			end
		end
	end

	done_after_ready: assert property (@(posedge clk) disable iff (reset)
		done |-> $past(res.ready));

endmodule

//--- verilog/float_unpack.sv
module float_unpack
	import fpu_types_pkg::*, fpu_const_pkg::*;
(
	input	fp32_t			word,
	fpu_operand_if.src		op
);

	logic	[7:0]	exp_field;
	logic	[22:0]	frac;
	logic			exp_ones;

	assign exp_field = word[30:23];
	assign frac = word[22:0];
	assign exp_ones = exp_field == 8'hff;

	assign op.sgn = word[31];

	// subnormals flush to zero here
	assign op.zero = exp_field == 8'd0;

	assign op.inf = exp_ones && (frac == 23'd0);
	assign op.snan = exp_ones && (frac != 23'd0) && !frac[22];
	assign op.qnan = exp_ones && frac[22];

	assign op.man = op.zero ? 24'd0 : {1'b1, frac};
	assign op.exp = {2'b00, exp_field} - EXP_BIAS;

endmodule

//--- verilog/fp_add_unit.sv
module fp_add_unit
	import fpu_types_pkg::*;
(
	input	logic	clk,
	input	logic	reset,
	input	logic	start,
	input	logic	sub,
	input	rm_t	rm,
	input	fp32_t	a,
	input	fp32_t	b,
	output	fp32_t	y,
	output	logic	invalid,
	output	logic	overflow,
	output	logic	underflow,
	output	logic	inexact,
	output	logic	done
);

	logic	op_add;
	logic	op_sub;

	fpu_operand_if	op_a ();
	fpu_operand_if	op_b ();
	fpu_result_if	sum_res ();

	assign op_add = start & ~sub;
	assign op_sub = start & sub;

	float_unpack unpack_a (
		.word(a),
		.op(op_a)
	);

	float_unpack unpack_b (
		.word(b),
		.op(op_b)
	);

	float_adder adder (
		.clk(clk),
		.reset(reset),
		.load(start),
		.op_add(op_add),
		.op_sub(op_sub),
		.rm(rm),
		.a(op_a),
		.b(op_b),
		.res(sum_res)
	);

	float_round_pack round_pack (
		.clk(clk),
		.reset(reset),
		.start(start),
		.rm(rm),
		.res(sum_res),
		.y(y),
		.invalid(invalid),
		.overflow(overflow),
		.underflow(underflow),
		.inexact(inexact),
		.done(done)
	);

endmodule
